// ==== verification/timer_cases.txt ====
# name refill_hex wait_cycles irq_enable expected_level expected_overflow
# level is the FIFO level after the run, capped at the FIFO depth of 8
wrap_irq ffffff00 300 1 1 0
log_four fffffffa 30 1 4 0
no_irq ffffffe0 70 0 2 0
overflow fffffffc 60 1 8 1
quiet ffff0000 40 1 0 0
single_late fffffff0 17 0 1 0

// ==== flist.f ====
+incdir+common
common/bus_pkg.sv
common/timer_pkg.sv
source/periph_decode.sv
timer/timer.sv
event_fifo/event_fifo.sv
event_fifo/event_reader.sv
source/timer_subsys_top.sv
verification/timer_subsys_asserts.sv
verification/timer_subsys_checker.sv
verification/tb_timer_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the timer subsystem testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f \
    --top-module tb_timer_subsys -o sim_tb_timer_subsys

status=0
./obj_dir/sim_tb_timer_subsys > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Testbench failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== verification/tb_timer_subsys.sv ====
// Testbench for the timer subsystem.
// Runs register readback, then the wrap cases read from the case file.
module tb_timer_subsys;
    timeunit 1ns;
    timeprecision 100ps;

    import bus_pkg::*;

    localparam logic [7:0] TIMER_CONTROL = 8'h00;
    localparam logic [7:0] TIMER_REFILL  = 8'h04;
    localparam logic [7:0] TIMER_COUNT   = 8'h08;
    localparam logic [7:0] EVT_STATUS    = 8'h10;
    localparam logic [7:0] EVT_DATA      = 8'h14;
    localparam logic [7:0] EVT_CONTROL   = 8'h18;

    logic     bus;
    logic     rst_n;
    bus_req_t req;
    bus_rsp_t rsp;
    logic     timer_irq;
    logic     event_irq;

    int    seed;
    int    check_issued;
    int    next_seq;        // seq of the next wrap, dropped ones included.
    string case_name[$];
    word_t case_refill[$];
    int    case_wait[$];
    int    case_irq[$];
    int    case_events[$];
    int    case_ovf[$];

    timer_subsys_top UUT (
        .bus       (bus),
        .rst_n     (rst_n),
        .req       (req),
        .rsp       (rsp),
        .timer_irq (timer_irq),
        .event_irq (event_irq)
    );

    timer_subsys_checker chk (
        .rsp       (rsp),
        .timer_irq (timer_irq),
        .event_irq (event_irq)
    );

    always #4 bus = ~bus;

    task automatic check(input int kind, input word_t expected, input string what);
        chk.test_name = what;
        chk.kind      = kind;
        chk.expected  = expected;
        check_issued++;
        -> chk.check_ev;
        wait (chk.done_count == check_issued);
    endtask

    // all bus tasks start and end 1 ns after a rising edge.
    task automatic bus_write(input logic [7:0] addr, input word_t data, input logic [3:0] strobe);
        req.valid   = 1'b1;
        req.address = addr;
        req.wstrobe = strobe;
        req.wdata   = data;
        @(posedge bus);
        #1;
        req = '0;
    endtask

    task automatic bus_read_check(input logic [7:0] addr, input word_t expected, input string what);
        req.valid   = 1'b1;
        req.address = addr;
        req.wstrobe = '0;
        req.wdata   = '0;
        #3;  // mid cycle, rdata settled.
        check(0, expected, what);
        @(posedge bus);
        #1;
        req = '0;
    endtask

    // wraps in a run of enabled cycles: first at offset n, then every n + 1.
    function automatic int wraps_in(input word_t refill, input int cycles);
        longint n;
        n = 64'h1_0000_0000 - longint'(refill);
        if (longint'(cycles) <= n) begin
            return 0;
        end
        return int'((longint'(cycles) - 1 - n) / (n + 1)) + 1;
    endfunction

    task automatic load_cases();
        int    fd;
        int    rc;
        string line;
        string name;
        word_t refill;
        int    w;
        int    en;
        int    ev;
        int    ov;
        fd = $fopen("verification/timer_cases.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc > 1 && line[0] != 8'h23) begin  // skip comment lines.
                rc = $sscanf(line, "%s %h %d %d %d %d", name, refill, w, en, ev, ov);
                if (rc == 6) begin
                    case_name.push_back(name);
                    case_refill.push_back(refill);
                    case_wait.push_back(w);
                    case_irq.push_back(en);
                    case_events.push_back(ev);
                    case_ovf.push_back(ov);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic readback_test();
        word_t rand_word;
        word_t old_word;
        word_t merged;
        word_t ctrl;
        bus_read_check(TIMER_CONTROL, '0, "reset control");
        bus_read_check(TIMER_REFILL, '0, "reset refill");
        bus_read_check(TIMER_COUNT, '0, "reset count");
        bus_read_check(EVT_STATUS, '0, "reset status");
        bus_read_check(EVT_CONTROL, '0, "reset event control");
        old_word = $random(seed);
        bus_write(TIMER_REFILL, old_word, 4'hf);
        rand_word = $random(seed);
        merged = {old_word[31:24], rand_word[23:16], old_word[15:8], rand_word[7:0]};
        bus_write(TIMER_REFILL, rand_word, 4'b0101);
        bus_read_check(TIMER_REFILL, merged, "refill byte merge");
        rand_word = $random(seed);
        ctrl = {rand_word[31:4], 4'b1010};  // refill load and irq enable, count off.
        bus_write(TIMER_CONTROL, ctrl, 4'hf);
        @(posedge bus);
        #1;
        bus_read_check(TIMER_CONTROL, {ctrl[31:4], 4'b0010}, "control readback");
        bus_read_check(TIMER_COUNT, merged, "count loaded");
        bus_write(TIMER_CONTROL, '0, 4'hf);
    endtask

    task automatic run_case(input int idx);
        string name;
        word_t refill;
        int    w;
        int    en;
        int    total;
        int    level;
        int    flag;
        name   = case_name[idx];
        refill = case_refill[idx];
        w      = case_wait[idx];
        en     = case_irq[idx] != 0 ? 1 : 0;
        total  = wraps_in(refill, w);
        level  = case_events[idx];
        bus_write(EVT_CONTROL, 32'(en), 4'hf);
        bus_write(TIMER_REFILL, refill, 4'hf);
        bus_write(TIMER_CONTROL, 32'h8, 4'hf);
        bus_write(TIMER_CONTROL, {30'b0, en[0], 1'b1}, 4'hf);
        // count enabled for exactly w cycles from here.
        repeat (w - 2) @(posedge bus);
        #1;
        flag = (en == 1 && wraps_in(refill, w - 2) > 0) ? 1 : 0;
        check(1, 32'(flag), {name, " timer irq"});
        bus_read_check(TIMER_CONTROL, {29'b0, flag[0], en[0], 1'b1}, {name, " control flag"});
        bus_write(TIMER_CONTROL, {30'b0, en[0], 1'b0}, 4'hf);
        check(1, '0, {name, " timer irq cleared"});
        check(2, 32'(en == 1 && level > 0), {name, " event irq"});
        bus_read_check(EVT_STATUS, (32'(case_ovf[idx]) << 16) | 32'(level), {name, " status"});
        if (case_ovf[idx] != 0) begin
            bus_write(EVT_STATUS, '0, 4'hf);
            bus_read_check(EVT_STATUS, 32'(level), {name, " overflow cleared"});
        end
        for (int i = 0; i < level; i++) begin
            bus_read_check(EVT_DATA, {16'(next_seq + i), refill[15:0]},
                           $sformatf("%s record %0d", name, i));
            check(2, 32'(en == 1 && level - i - 1 > 0), $sformatf("%s event irq %0d", name, i));
        end
        bus_read_check(EVT_STATUS, '0, {name, " drained"});
        next_seq += total;
    endtask

    initial begin
        int limit_cycles;
        bus          = 1'b0;
        rst_n        = 1'b0;
        req          = '0;
        seed         = 24854;
        check_issued = 0;
        next_seq     = 0;
        load_cases();
        limit_cycles = 200;  // readback phase.
        foreach (case_wait[i]) begin
            limit_cycles += case_wait[i] + 200;
        end
        fork
            begin
                #(limit_cycles * 8);
                $display("timeout after %0d cycles, DUT did not finish", limit_cycles);
                $display("Testbench failed");
                $finish;
            end
        join_none
        repeat (2) @(posedge bus);
        #1;
        rst_n = 1'b1;
        if (case_name.size() == 0) begin
            $display("no test cases could be read from the case file");
            chk.error_count++;
        end
        readback_test();
        foreach (case_name[i]) begin
            run_case(i);
        end
        $display("errors %0d in %0d checks", chk.error_count, check_issued);
        if (chk.error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verification/timer_subsys_checker.sv ====
// Result checker for the timer subsystem testbench.
// Compares read data and interrupt levels when the testbench asks.
module timer_subsys_checker (
    input bus_pkg::bus_rsp_t rsp,
    input logic              timer_irq,
    input logic              event_irq
);
    timeunit 1ns;
    timeprecision 100ps;

    import bus_pkg::*;

    localparam int KIND_RDATA     = 0;
    localparam int KIND_TIMER_IRQ = 1;
    localparam int KIND_EVENT_IRQ = 2;

    string test_name;
    int    kind;
    word_t expected;
    word_t actual;
    event  check_ev;       // fired by the testbench at a stable sample point.
    int    done_count;
    int    error_count;

    initial begin
        test_name   = "";
        kind        = KIND_RDATA;
        expected    = '0;
        actual      = '0;
        done_count  = 0;
        error_count = 0;
    end

    always @(check_ev) begin
        case (kind)
            KIND_RDATA:     actual = rsp.rdata;
            KIND_TIMER_IRQ: actual = {31'b0, timer_irq};
            default:        actual = {31'b0, event_irq};
        endcase
        if (kind == KIND_RDATA && rsp.ready !== 1'b1) begin
            error_count++;
            $display("bus ready was low during the read in %s", test_name);
        end
        if (actual !== expected) begin
            error_count++;
            if (kind == KIND_TIMER_IRQ && expected == 32'd1) begin
                $display("timer interrupt never rose in %s", test_name);
            end else if (kind == KIND_EVENT_IRQ && expected == 32'd1) begin
                $display("event interrupt never rose in %s", test_name);
            end else begin
                $display("MISMATCH %s expected %h actual %h", test_name, expected, actual);
            end
        end
        done_count++;
    end

endmodule

// ==== verification/timer_subsys_asserts.sv ====
// Bus and event FIFO properties for the timer subsystem.
// Bound into the top level on the decoder and FIFO connections.
`include "periph_cfg.svh"

module timer_subsys_asserts (
    input logic                        bus,
    input logic                        rst_n,
    input bus_pkg::bus_req_t           req,
    input bus_pkg::bus_rsp_t           rsp,
    input bus_pkg::bus_req_t           timer_req,
    input bus_pkg::bus_req_t           evt_req,
    input logic                        evt_push,
    input logic                        pop,
    input logic [`EVT_LEVEL_WIDTH-1:0] level
);
    timeunit 1ns;
    timeprecision 100ps;

    ready_follows_valid: assert property (@(posedge bus) rsp.ready == req.valid)
        else $error("bus ready does not follow valid");

    one_region: assert property (@(posedge bus) !(timer_req.valid && evt_req.valid))
        else $error("both regions selected in one cycle");

    level_in_range: assert property (@(posedge bus) disable iff (!rst_n)
        level <= `EVT_FIFO_DEPTH)
        else $error("FIFO level above depth");

    // level only moves on a push or a pop.
    level_steady: assert property (@(posedge bus) disable iff (!rst_n)
        (!evt_push && !pop) |=> $stable(level))
        else $error("FIFO level changed without push or pop");

endmodule

bind timer_subsys_top timer_subsys_asserts u_asserts (
    .bus       (bus),
    .rst_n     (rst_n),
    .req       (req),
    .rsp       (rsp),
    .timer_req (timer_req),
    .evt_req   (evt_req),
    .evt_push  (evt_push),
    .pop       (pop),
    .level     (level)
);

// ==== source/timer_subsys_top.sv ====
// Timer subsystem top level.
// Joins the decoder, timer, event FIFO and event reader on one bus.
`include "periph_cfg.svh"

module timer_subsys_top (
    input  logic              bus,
    input  logic              rst_n,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp,
    output logic              timer_irq,
    output logic              event_irq
);

    import bus_pkg::*;
    import timer_pkg::*;

    bus_req_t                    timer_req;
    bus_req_t                    evt_req;
    word_t                       timer_rdata;
    word_t                       evt_rdata;
    logic                        evt_push;
    timer_event_t                evt_data;
    logic                        pop;
    logic                        clear_overflow;
    timer_event_t                head;
    logic [`EVT_LEVEL_WIDTH-1:0] level;
    logic                        overflow;

    periph_decode u_decode (
        .bus         (bus),
        .req         (req),
        .timer_req   (timer_req),
        .evt_req     (evt_req),
        .timer_rdata (timer_rdata),
        .evt_rdata   (evt_rdata),
        .rsp         (rsp)
    );

    timer u_timer (
        .bus      (bus),
        .rst_n    (rst_n),
        .req      (timer_req),
        .rdata    (timer_rdata),
        .irq      (timer_irq),
        .evt_push (evt_push),
        .evt_data (evt_data)
    );

    event_fifo u_fifo (
        .bus            (bus),
        .rst_n          (rst_n),
        .push           (evt_push),
        .push_data      (evt_data),
        .pop            (pop),
        .clear_overflow (clear_overflow),
        .head           (head),
        .level          (level),
        .overflow       (overflow)
    );

    event_reader u_reader (
        .bus            (bus),
        .rst_n          (rst_n),
        .req            (evt_req),
        .rdata          (evt_rdata),
        .pop            (pop),
        .clear_overflow (clear_overflow),
        .head           (head),
        .level          (level),
        .overflow       (overflow),
        .irq            (event_irq)
    );

endmodule

// ==== event_fifo/event_reader.sv ====
// Bus register block for the event FIFO.
// Status, data pop and irq enable, plus the event interrupt.
`include "periph_cfg.svh"

module event_reader (
    input  logic                        bus,
    input  logic                        rst_n,
    input  bus_pkg::bus_req_t           req,
    output bus_pkg::word_t              rdata,
    output logic                        pop,
    output logic                        clear_overflow,
    input  timer_pkg::timer_event_t     head,
    input  logic [`EVT_LEVEL_WIDTH-1:0] level,
    input  logic                        overflow,
    output logic                        irq
);

    import bus_pkg::*;
    import timer_pkg::*;

    local_addr_t local_addr;
    logic        irq_enable;
    logic        write_en;
    logic        read_en;
    word_t       status_word;
    word_t       control_word;
    word_t       control_next;

    assign local_addr = req.address[BYTE_OFFSET_BITS +: `PERIPH_LOCAL_ADDR_WIDTH];
    assign write_en   = req.valid && (req.wstrobe != '0);
    assign read_en    = req.valid && (req.wstrobe == '0);

    // data read pops at the edge, never on an empty FIFO.
    assign pop            = read_en && (local_addr == EVT_DATA_ADDRESS) && (level != '0);
    assign clear_overflow = write_en && (local_addr == EVT_STATUS_ADDRESS);

    always_comb begin
        status_word                   = '0;
        status_word[`EVT_LEVEL_WIDTH-1:0] = level;
        status_word[EVT_OVERFLOW_BIT] = overflow;
    end

    assign control_word = {{(`PERIPH_WORD_WIDTH-1){1'b0}}, irq_enable};
    assign control_next = write_merge(control_word, req.wdata, req.wstrobe);

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            irq_enable <= 1'b0;
        end else if (write_en && local_addr == EVT_CONTROL_ADDRESS) begin
            irq_enable <= control_next[0];
        end
    end

    always_comb begin
        case (local_addr)
            EVT_STATUS_ADDRESS:  rdata = status_word;
            EVT_DATA_ADDRESS:    rdata = head;  // record read back raw.
            EVT_CONTROL_ADDRESS: rdata = control_word;
            default:             rdata = '0;
        endcase
    end

    assign irq = irq_enable && (level != '0);

endmodule

// ==== event_fifo/event_fifo.sv ====
// Circular FIFO of timer wrap records.
// Keeps an occupancy count and a sticky overflow flag for dropped pushes.
`include "periph_cfg.svh"

module event_fifo (
    input  logic                         bus,
    input  logic                         rst_n,
    input  logic                         push,
    input  timer_pkg::timer_event_t      push_data,
    input  logic                         pop,
    input  logic                         clear_overflow,
    output timer_pkg::timer_event_t      head,
    output logic [`EVT_LEVEL_WIDTH-1:0]  level,
    output logic                         overflow
);

    import timer_pkg::*;

    localparam int PTR_WIDTH = $clog2(`EVT_FIFO_DEPTH);

    timer_event_t         mem [`EVT_FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic                 full;
    logic                 empty;
    logic                 do_push;
    logic                 do_pop;

    assign full    = (level == `EVT_FIFO_DEPTH);
    assign empty   = (level == '0);
    assign do_push = push && !full;   // full drops the newest record.
    assign do_pop  = pop && !empty;

    always_ff @(posedge bus) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // a drop in the same cycle as a clear still counts.
    always_ff @(posedge bus) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1;
        end else if (clear_overflow) begin
            overflow <= 1'b0;
        end
    end

    assign head = mem[rd_ptr];

endmodule

// ==== timer/timer.sv ====
// Up-counting timer with refill reload and sticky interrupt flag.
// Emits a wrap event record on every reload through zero.
`include "periph_cfg.svh"

module timer (
    input  logic                    bus,
    input  logic                    rst_n,
    input  bus_pkg::bus_req_t       req,
    output bus_pkg::word_t          rdata,
    output logic                    irq,
    output logic                    evt_push,
    output timer_pkg::timer_event_t evt_data
);

    import bus_pkg::*;
    import timer_pkg::*;

    local_addr_t local_addr;
    timer_ctrl_u ctrl_reg;
    word_t       refill_reg;
    word_t       count_reg;
    logic [15:0] seq_reg;
    logic        write_en;
    logic        wrap;

    assign local_addr = req.address[BYTE_OFFSET_BITS +: `PERIPH_LOCAL_ADDR_WIDTH];
    assign write_en   = req.valid && (req.wstrobe != '0);
    assign wrap       = ctrl_reg.fields.count_enable && (count_reg == '0);

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            ctrl_reg.raw <= '0;
        end else if (write_en && local_addr == CONTROL_ADDRESS) begin
            ctrl_reg.raw <= write_merge(ctrl_reg.raw, req.wdata, req.wstrobe);
        end else begin
            ctrl_reg.fields.refill_enable <= 1'b0;  // one-shot load.
            if (wrap && ctrl_reg.fields.irq_enable) begin
                ctrl_reg.fields.irq_flag <= 1'b1;
            end
        end
    end

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            refill_reg <= '0;
        end else if (write_en && local_addr == REFILL_ADDRESS) begin
            refill_reg <= write_merge(refill_reg, req.wdata, req.wstrobe);
        end
    end

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            count_reg <= '0;
        end else if (ctrl_reg.fields.refill_enable || wrap) begin
            count_reg <= refill_reg;  // refill load or reload on the zero cycle.
        end else if (ctrl_reg.fields.count_enable) begin
            count_reg <= count_reg + 1'b1;
        end
    end

    // wrap sequence number, advances with each pushed record.
    always_ff @(posedge bus) begin
        if (!rst_n) begin
            seq_reg <= '0;
        end else if (wrap) begin
            seq_reg <= seq_reg + 1'b1;
        end
    end

    assign evt_push           = wrap;
    assign evt_data.seq       = seq_reg;
    assign evt_data.refill_lo = refill_reg[15:0];

    always_comb begin
        case (local_addr)
            CONTROL_ADDRESS: rdata = ctrl_reg.raw;
            REFILL_ADDRESS:  rdata = refill_reg;
            default:         rdata = count_reg;  // 2 and 3.
        endcase
    end

    assign irq = ctrl_reg.fields.irq_flag;

endmodule

// ==== source/periph_decode.sv ====
// Address decoder for the peripheral bus.
// Routes requests to the timer or event region and muxes read data back.
`include "periph_cfg.svh"

module periph_decode (
    input  logic              bus,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_req_t timer_req,
    output bus_pkg::bus_req_t evt_req,
    input  bus_pkg::word_t    timer_rdata,
    input  bus_pkg::word_t    evt_rdata,
    output bus_pkg::bus_rsp_t rsp
);

    logic evt_sel;  // high selects the event region.

    assign evt_sel = req.address[`PERIPH_REGION_BIT];

    // both regions see the full request, only one gets valid.
    always_comb begin
        timer_req       = req;
        timer_req.valid = req.valid && !evt_sel;
    end

    always_comb begin
        evt_req       = req;
        evt_req.valid = req.valid && evt_sel;
    end

    // no wait states on this bus.
    assign rsp.ready = req.valid;

    always_comb begin
        if (evt_sel) begin
            rsp.rdata = evt_rdata;
        end else begin
            rsp.rdata = timer_rdata;
        end
    end

endmodule

// ==== common/timer_pkg.sv ====
// Timer and event reader register map.
// Control word layout and the wrap event record.
`include "periph_cfg.svh"

package timer_pkg;

    typedef logic [`PERIPH_LOCAL_ADDR_WIDTH-1:0] local_addr_t;

    // timer region; the count register answers at 2 and 3.
    localparam local_addr_t CONTROL_ADDRESS = 2'd0;
    localparam local_addr_t REFILL_ADDRESS  = 2'd1;

    // event region.
    localparam local_addr_t EVT_STATUS_ADDRESS  = 2'd0;
    localparam local_addr_t EVT_DATA_ADDRESS    = 2'd1;
    localparam local_addr_t EVT_CONTROL_ADDRESS = 2'd2;

    // status word layout.
    localparam int EVT_OVERFLOW_BIT = 16;

    typedef struct packed {
        logic [`PERIPH_WORD_WIDTH-5:0] reserved;
        logic                          refill_enable;  // bit 3.
        logic                          irq_flag;       // bit 2.
        logic                          irq_enable;     // bit 1.
        logic                          count_enable;   // bit 0.
    } timer_ctrl_fields_t;

    // bus side sees the raw word, the timer decodes the fields.
    typedef union packed {
        bus_pkg::word_t     raw;
        timer_ctrl_fields_t fields;
    } timer_ctrl_u;

    // one record per wrap, fits one bus word.
    typedef struct packed {
        logic [15:0] seq;
        logic [15:0] refill_lo;
    } timer_event_t;

endpackage

// ==== common/bus_pkg.sv ====
// Peripheral bus types.
// Request and response records plus the byte lane write merge.
`include "periph_cfg.svh"

package bus_pkg;

    localparam int STROBE_WIDTH = `PERIPH_WORD_WIDTH / 8;
    localparam int BYTE_OFFSET_BITS = $clog2(STROBE_WIDTH);  // low address bits inside a word.

    typedef logic [`PERIPH_WORD_WIDTH-1:0] word_t;
    typedef logic [`PERIPH_ADDR_WIDTH-1:0] addr_t;
    typedef logic [STROBE_WIDTH-1:0]       strobe_t;

    typedef struct packed {
        logic    valid;
        addr_t   address;
        strobe_t wstrobe;  // nonzero means write.
        word_t   wdata;
    } bus_req_t;

    typedef struct packed {
        logic  ready;
        word_t rdata;
    } bus_rsp_t;

    // replace the byte lanes of old_word that have their strobe set.
    function automatic word_t write_merge(
        input word_t   old_word,
        input word_t   wdata,
        input strobe_t wstrobe
    );
        word_t merged;
        merged = old_word;
        for (int i = 0; i < STROBE_WIDTH; i++) begin
            if (wstrobe[i]) begin
                merged[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// ==== common/periph_cfg.svh ====
// Peripheral subsystem sizes.
// Bus widths, register window layout and event FIFO depth.
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

`define PERIPH_WORD_WIDTH 32       // bus data width.
`define PERIPH_ADDR_WIDTH 8        // byte address width.

// word select bits inside one region, above the byte offset.
`define PERIPH_LOCAL_ADDR_WIDTH 2

// address bit that picks the event region over the timer region.
`define PERIPH_REGION_BIT 4

`define EVT_FIFO_DEPTH 8           // any power of two.

// occupancy count needs one bit more than the pointers.
`define EVT_LEVEL_WIDTH ($clog2(`EVT_FIFO_DEPTH) + 1)

`endif
